// ==== include/fb_params.svh ====
/* framebuffer geometry and colour depth, included by every file that sizes
   coordinates, pixel byte indices or colour values */
`ifndef FB_PARAMS_SVH
`define FB_PARAMS_SVH

// framebuffer size in pixels
`define FB_COLUMNS 16
`define FB_ROWS 8

// colour depth, the design supports 1 to 4 bytes per pixel
`define BYTES_PER_PIXEL 2
`define COLOR_BITS (`BYTES_PER_PIXEL * 8)

// address widths derived from the geometry
`define COL_BITS $clog2(`FB_COLUMNS)
`define ROW_BITS $clog2(`FB_ROWS)

// byte index within a pixel, kept at least one bit wide for single-byte pixels
`define PIX_BITS ((`BYTES_PER_PIXEL > 1) ? $clog2(`BYTES_PER_PIXEL) : 1)

`endif

// ==== hw/fb_types_pkg.sv ====
/* data types that describe framebuffer contents: coordinates, fill rectangles
   and the byte write that the fill engine hands to the RAM */
`include "fb_params.svh"

package fb_types_pkg;

    // one pixel position in the framebuffer
    typedef struct packed {
        logic [`ROW_BITS-1:0] row;
        logic [`COL_BITS-1:0] column;
    } fb_coord_t;

    // width and height carry one extra bit so a full-screen rectangle fits
    typedef struct packed {
        logic [`COL_BITS-1:0]   x1;
        logic [`ROW_BITS-1:0]   y1;
        logic [`COL_BITS:0]     width;
        logic [`ROW_BITS:0]     height;
        logic [`COLOR_BITS-1:0] color;
    } fill_rect_t;

    // a single byte store into the framebuffer
    typedef struct packed {
        fb_coord_t            coord;
        logic [`PIX_BITS-1:0] pixel;
        logic [7:0]           data;
        logic                 write_enable;
    } fb_write_t;

endpackage

// ==== hw/gfx_cmd_pkg.sv ====
/* command and control types of the fill unit: host register map and the
   states of the fill engine */
package gfx_cmd_pkg;

    // host register addresses, a write to REG_GO launches the fill
    typedef enum logic [2:0] {
        REG_X1     = 3'd0,
        REG_Y1     = 3'd1,
        REG_WIDTH  = 3'd2,
        REG_HEIGHT = 3'd3,
        REG_COLOR  = 3'd4,
        REG_GO     = 3'd5
    } reg_addr_e;

    // fill engine states
    typedef enum logic [1:0] {
        ST_PRIME    = 2'd0,
        ST_WRITE    = 2'd1,
        ST_WAIT_ACK = 2'd2
    } fill_state_e;

endpackage

// ==== hw/fill_regs.sv ====
`timescale 1ns/1ps
/* host register block of the fill unit, holds the rectangle and turns a GO
   write into the run level that keeps the engine going until acknowledged */
`include "fb_params.svh"

module fill_regs
    import fb_types_pkg::*;
    import gfx_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        reg_write,
    input  reg_addr_e   reg_addr,
    input  logic [15:0] reg_data,
    input  logic        ack,
    input  logic        engine_done,
    output fill_rect_t  rect,
    output logic        run,
    output logic        busy
);
    logic accept;

    // while a fill is running the host cannot touch the rectangle or relaunch
    assign accept = reg_write && !run;

    // run rises after GO and falls once the host acknowledges the finished fill
    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
        end else if (accept && reg_addr == REG_GO) begin
            run <= 1'b1;
        end else if (ack && engine_done) begin
            run <= 1'b0;
        end
    end

    // the unit counts as busy for exactly the span of run
    assign busy = run;

    // rectangle fields, narrower fields take the low bits of the host data
    always_ff @(posedge clk) begin
        if (accept) begin
            case (reg_addr)
                REG_X1: begin
                    rect.x1 <= reg_data[`COL_BITS-1:0];
                end
                REG_Y1: begin
                    rect.y1 <= reg_data[`ROW_BITS-1:0];
                end
                REG_WIDTH: begin
                    rect.width <= reg_data[`COL_BITS:0];
                end
                REG_HEIGHT: begin
                    rect.height <= reg_data[`ROW_BITS:0];
                end
                REG_COLOR: begin
                    // colours wider than 16 bits are shifted in, high half first
                    rect.color <= (`COLOR_BITS)'({rect.color, reg_data});
                end
                default: begin
                    rect <= rect;
                end
            endcase
        end
    end

endmodule

// ==== hw/fill_area_engine.sv ====
`timescale 1ns/1ps
/* fill engine, walks a rectangle from its far corner back to the origin and
   presents one framebuffer byte write per cycle in which step is high */
`include "fb_params.svh"

module fill_area_engine
    import fb_types_pkg::*;
    import gfx_cmd_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       run,
    input  logic       step,
    input  logic       ack,
    input  fill_rect_t rect,
    output fb_write_t  wr,
    output logic       access_toggle,
    output logic       done
);
    localparam logic [`PIX_BITS-1:0] last_pixel = (`PIX_BITS)'(`BYTES_PER_PIXEL - 1);

    fill_state_e          state;
    logic [`ROW_BITS-1:0] row;
    logic [`COL_BITS-1:0] column;
    logic [`COL_BITS-1:0] far_column;
    logic [`PIX_BITS-1:0] pixel;
    logic                 write_enable;

    // far corner sums are one bit wider, only the low bits address the RAM
    logic [`COL_BITS:0]   far_column_sum;
    logic [`ROW_BITS:0]   far_row_sum;
    logic                 at_origin;
    logic [7:0]           color_byte;

    assign far_column_sum = {1'b0, rect.x1} + rect.width - 1'b1;
    assign far_row_sum = {1'b0, rect.y1} + rect.height - 1'b1;

    // the byte at the origin with index 0 is the last one of the fill
    assign at_origin = (row == rect.y1) && (column == rect.x1) && (pixel == '0);

    // byte b of a pixel carries colour bits 8b+7 down to 8b
    assign color_byte = rect.color[{pixel, 3'b000} +: 8];

    assign wr = '{
        coord: '{row: row, column: column},
        pixel: pixel,
        data: color_byte,
        write_enable: write_enable
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_PRIME;
            row <= '0;
            column <= '0;
            far_column <= '0;
            pixel <= '0;
            write_enable <= 1'b0;
            access_toggle <= 1'b0;
            done <= 1'b0;
        end else begin
            case (state)
                ST_PRIME: begin
                    if (run && step) begin
                        row <= far_row_sum[`ROW_BITS-1:0];
                        column <= far_column_sum[`COL_BITS-1:0];
                        far_column <= far_column_sum[`COL_BITS-1:0];
                        pixel <= last_pixel;
                        write_enable <= 1'b1;
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (step) begin
                        // the RAM takes the current byte on this edge
                        access_toggle <= ~access_toggle;
                        if (at_origin) begin
                            write_enable <= 1'b0;
                            done <= 1'b1;
                            state <= ST_WAIT_ACK;
                        end else if (pixel != '0) begin
                            pixel <= pixel - 1'b1;
                        end else begin
                            pixel <= last_pixel;
                            if (column == rect.x1) begin
                                column <= far_column;
                                row <= row - 1'b1;
                            end else begin
                                column <= column - 1'b1;
                            end
                        end
                    end
                end
                ST_WAIT_ACK: begin
                    // ack is a single pulse, so this state does not pause on step
                    if (ack) begin
                        done <= 1'b0;
                        state <= ST_PRIME;
                    end
                end
                default: begin
                    state <= ST_PRIME;
                end
            endcase
        end
    end

endmodule

// ==== hw/frame_ram.sv ====
`timescale 1ns/1ps
/* byte-wide framebuffer memory, written by the fill engine and read back
   combinationally by pixel position and byte index */
`include "fb_params.svh"

module frame_ram
    import fb_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 step,
    input  fb_write_t            wr,
    input  fb_coord_t            rd_coord,
    input  logic [`PIX_BITS-1:0] rd_pixel,
    output logic [7:0]           rd_data
);
    // one byte per row, column and byte index of a pixel
    logic [7:0] mem [`FB_ROWS][`FB_COLUMNS][`BYTES_PER_PIXEL];

    // a write lands only on edges where the engine is stepping
    always_ff @(posedge clk) begin
        if (wr.write_enable && step) begin
            mem[wr.coord.row][wr.coord.column][wr.pixel] <= wr.data;
        end
    end

    assign rd_data = mem[rd_coord.row][rd_coord.column][rd_pixel];

endmodule

// ==== hw/gfx_fill_top.sv ====
`timescale 1ns/1ps
/* top level of the rectangle fill unit, host registers steer the fill engine
   which writes into the framebuffer RAM */
`include "fb_params.svh"

module gfx_fill_top
    import fb_types_pkg::*;
    import gfx_cmd_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 reg_write,
    input  reg_addr_e            reg_addr,
    input  logic [15:0]          reg_data,
    input  logic                 ack,
    input  logic                 step,
    input  fb_coord_t            rd_coord,
    input  logic [`PIX_BITS-1:0] rd_pixel,
    output logic [7:0]           rd_data,
    output logic                 busy,
    output logic                 done,
    output logic                 access_toggle
);
    fill_rect_t rect;
    fb_write_t  wr;
    logic       run;

    fill_regs regs0 (
        .clk         (clk),
        .reset       (reset),
        .reg_write   (reg_write),
        .reg_addr    (reg_addr),
        .reg_data    (reg_data),
        .ack         (ack),
        .engine_done (done),
        .rect        (rect),
        .run         (run),
        .busy        (busy)
    );

    fill_area_engine engine0 (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .step          (step),
        .ack           (ack),
        .rect          (rect),
        .wr            (wr),
        .access_toggle (access_toggle),
        .done          (done)
    );

    frame_ram ram0 (
        .clk      (clk),
        .step     (step),
        .wr       (wr),
        .rd_coord (rd_coord),
        .rd_pixel (rd_pixel),
        .rd_data  (rd_data)
    );

endmodule

// ==== tests/gfx_fill_assertions.sv ====
`timescale 1ns/1ps
/* concurrent checks on the fill engine, bound into fill_area_engine for simulation */
`include "fb_params.svh"

module gfx_fill_assertions
    import fb_types_pkg::*;
    import gfx_cmd_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        step,
    input fb_write_t   wr,
    input logic        access_toggle,
    input logic        done,
    input fill_state_e state
);
    int failure_count = 0;

    // a low step freezes the engine, so the presented write must not move on
    stall_freezes_write: assert property (
        @(posedge clk) disable iff (reset)
        (state == ST_WRITE && !step) |=> (wr == $past(wr) && access_toggle == $past(access_toggle))
    ) else begin
        $error("engine advanced its write while step was low");
        failure_count++;
    end

    done_without_write: assert property (
        @(posedge clk) disable iff (reset)
        done |-> !wr.write_enable
    ) else begin
        $error("write enable is high while done is set");
        failure_count++;
    end

    // each flip of the toggle marks one byte taken by the RAM
    toggle_follows_write: assert property (
        @(posedge clk) disable iff (reset)
        (access_toggle != $past(access_toggle)) |-> $past(wr.write_enable && step)
    ) else begin
        $error("access toggle flipped without a write");
        failure_count++;
    end

endmodule

bind fill_area_engine gfx_fill_assertions asserts0 (
    .clk           (clk),
    .reset         (reset),
    .step          (step),
    .wr            (wr),
    .access_toggle (access_toggle),
    .done          (done),
    .state         (state)
);

// ==== tests/gfx_fill_tb.sv ====
`timescale 1ns/1ps
/* testbench of the rectangle fill unit, runs a table of fills through the
   register port and compares the whole framebuffer against a byte model */
`include "fb_params.svh"

module gfx_fill_tb
    import fb_types_pkg::*;
    import gfx_cmd_pkg::*;
();
    typedef struct packed {
        fill_rect_t rect;
        logic       stall;
        logic       meddle;
    } test_entry_t;

    localparam int COLOR_WORDS = (`COLOR_BITS + 15) / 16;

    logic                 clk;
    logic                 reset;
    logic                 reg_write;
    reg_addr_e            reg_addr;
    logic [15:0]          reg_data;
    logic                 ack;
    logic                 step;
    fb_coord_t            rd_coord;
    logic [`PIX_BITS-1:0] rd_pixel;
    logic [7:0]           rd_data;
    logic                 busy;
    logic                 done;
    logic                 access_toggle;

    test_entry_t tests [$];
    logic [7:0]  model [`FB_ROWS][`FB_COLUMNS][`BYTES_PER_PIXEL];
    integer      seed;
    int          test_errors;
    int          total_errors;
    int          failed_tests;
    int          cycle_count;
    int          timeout_limit;

    gfx_fill_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .reg_write     (reg_write),
        .reg_addr      (reg_addr),
        .reg_data      (reg_data),
        .ack           (ack),
        .step          (step),
        .rd_coord      (rd_coord),
        .rd_pixel      (rd_pixel),
        .rd_data       (rd_data),
        .busy          (busy),
        .done          (done),
        .access_toggle (access_toggle)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %0t ns: %s expected 0x%0h, actual 0x%0h", $time, name, expected, actual);
        test_errors++;
    endtask

    task automatic add_test(input int x1, input int y1, input int width, input int height,
                            input int color, input logic stall, input logic meddle);
        test_entry_t entry;
        entry.rect.x1 = (`COL_BITS)'(x1);
        entry.rect.y1 = (`ROW_BITS)'(y1);
        entry.rect.width = (`COL_BITS + 1)'(width);
        entry.rect.height = (`ROW_BITS + 1)'(height);
        entry.rect.color = (`COLOR_BITS)'(color);
        entry.stall = stall;
        entry.meddle = meddle;
        tests.push_back(entry);
    endtask

    // one-cycle register strobe, entered and left on a falling edge
    task automatic write_reg(input reg_addr_e addr, input logic [15:0] data);
        reg_write = 1'b1;
        reg_addr = addr;
        reg_data = data;
        @(negedge clk);
        reg_write = 1'b0;
    endtask

    task automatic run_fill(input test_entry_t entry, output int flips);
        logic        last_toggle;
        logic [31:0] rand_word;
        int          cycle;
        write_reg(REG_X1, 16'(entry.rect.x1));
        write_reg(REG_Y1, 16'(entry.rect.y1));
        write_reg(REG_WIDTH, 16'(entry.rect.width));
        write_reg(REG_HEIGHT, 16'(entry.rect.height));
        for (int k = COLOR_WORDS - 1; k >= 0; k--) begin
            write_reg(REG_COLOR, 16'(entry.rect.color >> (16 * k)));
        end
        write_reg(REG_GO, 16'h0000);
        flips = 0;
        cycle = 0;
        last_toggle = access_toggle;
        while (done !== 1'b1) begin
            rand_word = $random(seed);
            step = entry.stall ? (rand_word[1:0] != 2'b00) : 1'b1;
            if (entry.meddle && cycle >= 1 && cycle <= 3) begin
                // host writes during the fill, the register block must drop them
                reg_write = 1'b1;
                reg_addr = (cycle == 1) ? REG_COLOR : ((cycle == 2) ? REG_X1 : REG_GO);
                reg_data = 16'(~entry.rect.color);
            end else begin
                reg_write = 1'b0;
            end
            @(negedge clk);
            if (access_toggle !== last_toggle)
                flips++;
            last_toggle = access_toggle;
            cycle++;
        end
        reg_write = 1'b0;
        step = 1'b1;
        // done and busy hold for as long as the host leaves them unacknowledged
        repeat (entry.meddle ? 20 : 2) begin
            if (done !== 1'b1)
                report_mismatch("done", 1, done);
            if (busy !== 1'b1)
                report_mismatch("busy", 1, busy);
            if (access_toggle !== last_toggle)
                report_mismatch("access_toggle", last_toggle, access_toggle);
            @(negedge clk);
        end
        ack = 1'b1;
        @(negedge clk);
        ack = 1'b0;
        step = 1'b0;
        if (done !== 1'b0)
            report_mismatch("done", 0, done);
        if (busy !== 1'b0)
            report_mismatch("busy", 0, busy);
    endtask

    // updates the model with the new rectangle, then reads back every byte
    task automatic check_image(input test_entry_t entry);
        int r_last;
        int c_last;
        r_last = int'(entry.rect.y1) + int'(entry.rect.height) - 1;
        c_last = int'(entry.rect.x1) + int'(entry.rect.width) - 1;
        for (int r = 0; r < `FB_ROWS; r++) begin
            for (int c = 0; c < `FB_COLUMNS; c++) begin
                for (int b = 0; b < `BYTES_PER_PIXEL; b++) begin
                    if (r >= int'(entry.rect.y1) && r <= r_last &&
                        c >= int'(entry.rect.x1) && c <= c_last)
                        model[r][c][b] = entry.rect.color[8 * b +: 8];
                    rd_coord.row = (`ROW_BITS)'(r);
                    rd_coord.column = (`COL_BITS)'(c);
                    rd_pixel = (`PIX_BITS)'(b);
                    @(negedge clk);
                    if (rd_data !== model[r][c][b])
                        report_mismatch($sformatf("rd_data[%0d][%0d][%0d]", r, c, b),
                                        model[r][c][b], rd_data);
                end
            end
        end
    endtask

    initial begin
        test_entry_t entry;
        int          flips;
        int          expected_flips;
        int          total_bytes;
        reset = 1'b1;
        reg_write = 1'b0;
        reg_addr = REG_X1;
        reg_data = '0;
        ack = 1'b0;
        step = 1'b0;
        rd_coord = '0;
        rd_pixel = '0;
        seed = 32'hf85e_ea2d;
        test_errors = 0;
        total_errors = 0;
        failed_tests = 0;
        cycle_count = 0;
        // x1, y1, width, height, colour, stall, writes while busy
        add_test(0, 0, 16, 8, 16'hc3a5, 1'b0, 1'b0);
        add_test(5, 2, 5, 3, 16'h0f1e, 1'b0, 1'b0);
        add_test(3, 1, 7, 4, 16'h7e81, 1'b1, 1'b0);
        add_test(9, 4, 4, 2, 16'h3c4d, 1'b0, 1'b1);
        add_test(15, 7, 1, 1, 16'hbeef, 1'b0, 1'b0);
        add_test(0, 7, 16, 1, 16'h2b60, 1'b0, 1'b0);
        add_test(15, 0, 1, 8, 16'h91d4, 1'b1, 1'b0);
        add_test(0, 0, 1, 1, 16'h6e07, 1'b0, 1'b0);
        total_bytes = 0;
        foreach (tests[i])
            total_bytes += int'(tests[i].rect.width) * int'(tests[i].rect.height) * `BYTES_PER_PIXEL;
        timeout_limit = total_bytes * 4 + 2000;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        if (busy !== 1'b0)
            report_mismatch("busy", 0, busy);
        if (done !== 1'b0)
            report_mismatch("done", 0, done);
        if (access_toggle !== 1'b0)
            report_mismatch("access_toggle", 0, access_toggle);
        $display("reset state: %s", (test_errors == 0) ? "ok" : "wrong");
        total_errors += test_errors;
        if (test_errors != 0)
            failed_tests++;
        foreach (tests[i]) begin
            entry = tests[i];
            test_errors = 0;
            run_fill(entry, flips);
            expected_flips = int'(entry.rect.width) * int'(entry.rect.height) * `BYTES_PER_PIXEL;
            if (flips != expected_flips)
                report_mismatch("access_toggle flips", expected_flips, flips);
            check_image(entry);
            $display("test %0d: (%0d,%0d) %0dx%0d colour 0x%0h stall %0b: %s, %0d errors",
                     i, entry.rect.x1, entry.rect.y1, entry.rect.width, entry.rect.height,
                     entry.rect.color, entry.stall, (test_errors == 0) ? "ok" : "wrong",
                     test_errors);
            total_errors += test_errors;
            if (test_errors != 0)
                failed_tests++;
        end
        if (dut0.engine0.asserts0.failure_count != 0) begin
            $display("fill engine assertions failed %0d times",
                     dut0.engine0.asserts0.failure_count);
            total_errors += dut0.engine0.asserts0.failure_count;
        end
        $display("tests run: %0d, failed: %0d, errors: %0d", tests.size() + 1, failed_tests,
                 total_errors);
        if (total_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
hw/fb_types_pkg.sv
hw/gfx_cmd_pkg.sv
hw/fill_regs.sv
hw/fill_area_engine.sv
hw/frame_ram.sv
hw/gfx_fill_top.sv
tests/gfx_fill_assertions.sv
tests/gfx_fill_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the fill unit testbench with Verilator, runs it and checks the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module gfx_fill_tb -f src.f -o gfx_fill_sim

# assertion errors are counted by the testbench, so the run must not stop at the first one
output="$(./obj_dir/gfx_fill_sim +verilator+error+limit+1000 2>&1 || true)"
echo "$output"
grep -q "Simulation PASSED" <<< "$output"
